// File: ex_pkg.sv
//////////////////////////////
// Execute stage widths and the ALU and multiplier opcodes
//////////////////////////////

package ex_pkg;

  // Data path and register file address widths
  parameter int DATA_W     = 32;
  parameter int REG_ADDR_W = 6;   // Top bit selects the FP half of the register file

  //////////////////////////////
  // ALU opcodes
  //////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,   // Signed compare
    ALU_SLTU = 4'd9,   // Unsigned compare
    ALU_EQ   = 4'd10,  // Branch compares
    ALU_NE   = 4'd11
  } alu_op_e;

  //////////////////////////////
  // Multiplier opcodes
  //////////////////////////////
  typedef enum logic [1:0] {
    MUL_LO    = 2'd0,  // Low word, single cycle
    MUL_HI    = 2'd1,  // High word of signed product, two cycles
    MUL_DOT16 = 2'd2,  // 2 x 16-bit lanes plus accumulator
    MUL_DOT8  = 2'd3   // 4 x 8-bit lanes plus accumulator
  } mult_op_e;

endpackage

// File: ex_result_if.sv
//////////////////////////////
// Result bundle from ALU and multiplier to their consumers
//////////////////////////////

`timescale 1ns/1ps

interface ex_result_if import ex_pkg::*; ();

  logic [DATA_W-1:0] alu_result;
  logic              alu_cmp;          // Comparison flag, also branch decision
  logic [DATA_W-1:0] mult_result;
  logic              mult_ready;       // Low while MULH is in its first cycle
  logic              mult_multicycle;  // High in the first MULH cycle

  // ALU side
  modport alu_src (output alu_result, output alu_cmp);

  // Multiplier side
  modport mult_src (output mult_result, output mult_ready, output mult_multicycle);

  // Forwarding mux and WB stage
  modport sink (
    input alu_result, input alu_cmp,
    input mult_result, input mult_ready, input mult_multicycle
  );

endinterface

// File: ex_alu.sv
//////////////////////////////
// Integer ALU with comparison flag for branches
//////////////////////////////

`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  logic              enable_i,
  input  alu_op_e           operator_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  ex_result_if.alu_src      res
);

  localparam int SHAMT_W = $clog2(DATA_W);

  logic [SHAMT_W-1:0] shamt;
  logic               is_equal;
  logic               is_less_s;
  logic               is_less_u;
  logic               cmp_flag;
  logic [DATA_W-1:0]  result;

  assign shamt     = operand_b_i[SHAMT_W-1:0];  // Only low bits count
  assign is_equal  = (operand_a_i == operand_b_i);
  assign is_less_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign is_less_u = (operand_a_i < operand_b_i);

  // Comparison flag
  always_comb begin
    case (operator_i)
      ALU_EQ:   cmp_flag = is_equal;
      ALU_NE:   cmp_flag = ~is_equal;
      ALU_SLT:  cmp_flag = is_less_s;
      ALU_SLTU: cmp_flag = is_less_u;
      default:  cmp_flag = 1'b0;  // Not a compare
    endcase
  end

  //////////////////////////////
  // Result mux
  //////////////////////////////
  always_comb begin
    case (operator_i)
      ALU_ADD: result = operand_a_i + operand_b_i;
      ALU_SUB: result = operand_a_i - operand_b_i;
      ALU_AND: result = operand_a_i & operand_b_i;
      ALU_OR:  result = operand_a_i | operand_b_i;
      ALU_XOR: result = operand_a_i ^ operand_b_i;
      ALU_SLL: result = operand_a_i << shamt;
      ALU_SRL: result = operand_a_i >> shamt;
      ALU_SRA: result = $signed(operand_a_i) >>> shamt;  // Keeps sign bit
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE: begin
        result = {{(DATA_W-1){1'b0}}, cmp_flag};  // Flag widened to a word
      end
      default: result = '0;
    endcase
  end

  // Idle ALU drives zeros so downstream logic stays quiet
  assign res.alu_result = enable_i ? result : '0;
  assign res.alu_cmp    = cmp_flag;

endmodule

// File: ex_mult.sv
//////////////////////////////
// Multiplier: MUL, two-cycle MULH, 16-bit and 8-bit dot products
//////////////////////////////

`timescale 1ns/1ps

module ex_mult import ex_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  mult_op_e          operator_i,
  input  logic [DATA_W-1:0] op_a_i,
  input  logic [DATA_W-1:0] op_b_i,
  input  logic [DATA_W-1:0] op_c_i,      // Dot product accumulator
  input  logic [DATA_W-1:0] dot_op_a_i,  // Weight or register operand
  input  logic [DATA_W-1:0] dot_op_b_i,
  input  logic              ex_ready_i,
  ex_result_if.mult_src     res
);

  localparam int N_LANE16 = DATA_W / 16;
  localparam int N_LANE8  = DATA_W / 8;

  typedef enum logic {
    IDLE,
    HI_STEP  // High word available from product register
  } mulh_state_e;

  mulh_state_e                state_q;
  mulh_state_e                state_d;
  logic                       hi_start;
  logic signed [2*DATA_W-1:0] prod_full;
  logic        [DATA_W-1:0]   prod_q;
  logic signed [DATA_W-1:0]   dot16_sum;
  logic signed [DATA_W-1:0]   dot8_sum;
  logic        [DATA_W-1:0]   mult_result;

  // Full signed product, low half also serves MUL
  assign prod_full = $signed(op_a_i) * $signed(op_b_i);

  // First MULH cycle
  assign hi_start = enable_i & (operator_i == MUL_HI) & (state_q == IDLE);

  //////////////////////////////
  // MULH sequencing
  //////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (hi_start) state_d = HI_STEP;
      HI_STEP: if (ex_ready_i) state_d = IDLE;  // Leave only when the stage moves on
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // High product register, loaded in the first MULH cycle
  always_ff @(posedge clk) begin
    if (hi_start) begin
      prod_q <= prod_full[2*DATA_W-1:DATA_W];
    end
  end

  //////////////////////////////
  // Dot products
  //////////////////////////////
  always_comb begin
    dot16_sum = $signed(op_c_i);
    for (int i = 0; i < N_LANE16; i++) begin
      dot16_sum = dot16_sum + $signed(dot_op_a_i[16*i +: 16]) * $signed(dot_op_b_i[16*i +: 16]);
    end
  end

  always_comb begin
    dot8_sum = $signed(op_c_i);
    for (int i = 0; i < N_LANE8; i++) begin
      dot8_sum = dot8_sum + $signed(dot_op_a_i[8*i +: 8]) * $signed(dot_op_b_i[8*i +: 8]);
    end
  end

  // Result select
  always_comb begin
    case (operator_i)
      MUL_LO:    mult_result = prod_full[DATA_W-1:0];
      MUL_HI:    mult_result = prod_q;  // Valid in HI_STEP
      MUL_DOT16: mult_result = dot16_sum;
      MUL_DOT8:  mult_result = dot8_sum;
      default:   mult_result = '0;
    endcase
  end

  assign res.mult_result     = mult_result;
  assign res.mult_multicycle = hi_start;
  assign res.mult_ready      = ~hi_start;  // Stall for the first MULH cycle only

endmodule

// File: ex_spr_file.sv
//////////////////////////////
// Weight SPR file and dot operand A select
//////////////////////////////

`timescale 1ns/1ps

module ex_spr_file import ex_pkg::*; #(
  parameter int N_WSPR = 4,                  // Power of two
  localparam int IDX_W = $clog2(N_WSPR)
) (
  input  logic              clk,
  input  logic              rst_n,

  // Write from the load write-back
  input  logic              wr_en_i,
  input  logic [IDX_W-1:0]  wr_idx_i,
  input  logic [DATA_W-1:0] wr_data_i,

  // Read for the dot product in EX
  input  logic              rd_en_i,
  input  logic [IDX_W-1:0]  rd_idx_i,
  input  logic [DATA_W-1:0] dot_op_a_i,
  output logic [DATA_W-1:0] dot_op_a_o
);

  logic [N_WSPR-1:0][DATA_W-1:0] weight_q;

  //////////////////////////////
  // Weight registers
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weight_q <= '0;  // Weights start cleared
    end else if (wr_en_i) begin
      weight_q[wr_idx_i] <= wr_data_i;  // One weight per load
    end
  end

  // Selected weight replaces the register operand
  assign dot_op_a_o = rd_en_i ? weight_q[rd_idx_i] : dot_op_a_i;

endmodule

// File: ex_wb_stage.sv
//////////////////////////////
// EX/WB register, delayed multiplier result, load write-back port
//////////////////////////////

`timescale 1ns/1ps

module ex_wb_stage import ex_pkg::*; #(
  parameter int N_WSPR = 4,
  localparam int IDX_W = $clog2(N_WSPR)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                  lsu_err_i,
  input  logic                  sprw_en_i,    // Weight tag of the instruction in EX
  input  logic [IDX_W-1:0]      sprw_idx_i,
  input  logic [DATA_W-1:0]     lsu_rdata_i,
  ex_result_if.sink             res,
  output logic                  regfile_we_wb_o,
  output logic [REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [DATA_W-1:0]     regfile_wdata_wb_o,
  output logic                  spr_wr_en_o,
  output logic [IDX_W-1:0]      spr_wr_idx_o
);

  logic                  we_q;
  logic [REG_ADDR_W-1:0] waddr_q;
  logic                  tag_en_q;
  logic [IDX_W-1:0]      tag_idx_q;
  logic [DATA_W-1:0]     mult_result_p;  // Multiplier result, one cycle old
  logic                  we_d;

  assign we_d = regfile_we_i & ~lsu_err_i;  // Faulting load never writes

  //////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q      <= 1'b0;
      waddr_q   <= '0;
      tag_en_q  <= 1'b0;
      tag_idx_q <= '0;
    end else if (ex_valid_i) begin  // Implies wb_ready_i
      we_q      <= we_d;
      tag_en_q  <= sprw_en_i;
      tag_idx_q <= sprw_idx_i;
      if (we_d) begin
        waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      we_q <= 1'b0;  // Bubble, nothing to write
    end
    // Back-pressure holds everything
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mult_result_p <= '0;
    end else begin
      mult_result_p <= res.mult_result;
    end
  end

  // Load write-back port
  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;
  assign regfile_wdata_wb_o = tag_en_q ? mult_result_p : lsu_rdata_i;

  // Tagged load goes to a weight SPR
  assign spr_wr_en_o  = we_q & tag_en_q;
  assign spr_wr_idx_o = tag_idx_q;

endmodule

// File: ex_fwd_ctrl.sv
//////////////////////////////
// Forwarding write port mux and EX ready/valid
//////////////////////////////

`timescale 1ns/1ps

module ex_fwd_ctrl import ex_pkg::*; (
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  csr_access_i,
  input  logic                  lsu_en_i,
  input  logic [DATA_W-1:0]     csr_rdata_i,
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  branch_in_ex_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  wb_ready_i,
  ex_result_if.sink             res,
  output logic                  regfile_alu_we_o,
  output logic [REG_ADDR_W-1:0] regfile_alu_waddr_o,
  output logic [DATA_W-1:0]     regfile_alu_wdata_o,
  output logic                  load_compute_o,
  output logic                  branch_decision_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic load_compute;
  logic units_ready;

  assign load_compute = alu_en_i & mult_en_i;  // ALU and MAC issued together

  //////////////////////////////
  // Forwarding port
  //////////////////////////////
  always_comb begin
    regfile_alu_wdata_o = '0;
    if (load_compute)      regfile_alu_wdata_o = res.alu_result;  // MAC goes out WB port
    else if (csr_access_i) regfile_alu_wdata_o = csr_rdata_i;
    else if (mult_en_i)    regfile_alu_wdata_o = res.mult_result;
    else if (alu_en_i)     regfile_alu_wdata_o = res.alu_result;
  end

  assign regfile_alu_we_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_o = regfile_alu_waddr_i;
  assign load_compute_o      = load_compute;
  assign branch_decision_o   = res.alu_cmp;

  // Handshake; valid goes right, ready goes left
  assign units_ready = res.mult_ready & lsu_ready_ex_i & wb_ready_i;
  assign ex_ready_o  = units_ready | branch_in_ex_i;  // Branches finish in EX
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

// File: ex_stage.sv
//////////////////////////////
// Execute stage top: ALU, multiplier, weight SPRs, EX/WB
//////////////////////////////

`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
  parameter int N_WSPR = 4,
  localparam int IDX_W = $clog2(N_WSPR)
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // ALU
  input  logic                  alu_en_i,
  input  alu_op_e               alu_operator_i,
  input  logic [DATA_W-1:0]     alu_operand_a_i,
  input  logic [DATA_W-1:0]     alu_operand_b_i,
  input  logic [DATA_W-1:0]     alu_operand_c_i,  // Jump target

  // Multiplier
  input  logic                  mult_en_i,
  input  mult_op_e              mult_operator_i,
  input  logic [DATA_W-1:0]     mult_operand_a_i,
  input  logic [DATA_W-1:0]     mult_operand_b_i,
  input  logic [DATA_W-1:0]     mult_operand_c_i,
  input  logic [DATA_W-1:0]     mult_dot_op_a_i,
  input  logic [DATA_W-1:0]     mult_dot_op_b_i,
  output logic                  mult_multicycle_o,

  // Weight tag
  input  logic                  sprw_en_i,
  input  logic [IDX_W-1:0]      sprw_idx_i,

  // LSU, CSR, control
  input  logic                  lsu_en_i,
  input  logic [DATA_W-1:0]     lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  csr_access_i,
  input  logic [DATA_W-1:0]     csr_rdata_i,
  input  logic                  branch_in_ex_i,
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                  wb_ready_i,

  // Forwarding port
  output logic                  regfile_alu_we_o,
  output logic [REG_ADDR_W-1:0] regfile_alu_waddr_o,
  output logic [DATA_W-1:0]     regfile_alu_wdata_o,
  output logic                  load_compute_o,

  // Load write-back port
  output logic                  regfile_we_wb_o,
  output logic [REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [DATA_W-1:0]     regfile_wdata_wb_o,

  output logic [DATA_W-1:0]     jump_target_o,
  output logic                  branch_decision_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  ex_result_if res ();

  logic [DATA_W-1:0] dot_op_a;   // Register operand or weight
  logic              spr_wr_en;
  logic [IDX_W-1:0]  spr_wr_idx;

  //////////////////////////////
  // Compute units
  //////////////////////////////
  ex_alu i_ex_alu (
    .enable_i    (alu_en_i),
    .operator_i  (alu_operator_i),
    .operand_a_i (alu_operand_a_i),
    .operand_b_i (alu_operand_b_i),
    .res         (res.alu_src)
  );

  ex_spr_file #(.N_WSPR(N_WSPR)) i_ex_spr_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en_i    (spr_wr_en),
    .wr_idx_i   (spr_wr_idx),
    .wr_data_i  (lsu_rdata_i),  // Weight comes straight from load data
    .rd_en_i    (sprw_en_i),
    .rd_idx_i   (sprw_idx_i),
    .dot_op_a_i (mult_dot_op_a_i),
    .dot_op_a_o (dot_op_a)
  );

  ex_mult i_ex_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (mult_en_i),
    .operator_i (mult_operator_i),
    .op_a_i     (mult_operand_a_i),
    .op_b_i     (mult_operand_b_i),
    .op_c_i     (mult_operand_c_i),
    .dot_op_a_i (dot_op_a),
    .dot_op_b_i (mult_dot_op_b_i),
    .ex_ready_i (ex_ready_o),
    .res        (res.mult_src)
  );

  //////////////////////////////
  // Write ports and control
  //////////////////////////////
  ex_wb_stage #(.N_WSPR(N_WSPR)) i_ex_wb_stage (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_o),
    .wb_ready_i         (wb_ready_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .lsu_err_i          (lsu_err_i),
    .sprw_en_i          (sprw_en_i),
    .sprw_idx_i         (sprw_idx_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .res                (res.sink),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_wdata_wb_o (regfile_wdata_wb_o),
    .spr_wr_en_o        (spr_wr_en),
    .spr_wr_idx_o       (spr_wr_idx)
  );

  ex_fwd_ctrl i_ex_fwd_ctrl (
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .wb_ready_i          (wb_ready_i),
    .res                 (res.sink),
    .regfile_alu_we_o    (regfile_alu_we_o),
    .regfile_alu_waddr_o (regfile_alu_waddr_o),
    .regfile_alu_wdata_o (regfile_alu_wdata_o),
    .load_compute_o      (load_compute_o),
    .branch_decision_o   (branch_decision_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

  assign jump_target_o     = alu_operand_c_i;  // Target computed in ID
  assign mult_multicycle_o = res.mult_multicycle;

endmodule

// File: tb_ex_stage_checker.sv
//////////////////////////////
// Bound assertions on the execute stage handshake and reset
//////////////////////////////

`timescale 1ns/1ps

module tb_ex_stage_checker (
  input logic clk,
  input logic rst_n,
  input logic ex_valid_i,
  input logic wb_ready_i,
  input logic mult_multicycle_i,
  input logic mult_ready_i,
  input logic regfile_we_wb_i
);

  int unsigned fail_count = 0;  // Failed assertions, read by the testbench top

  // Valid never goes out into a stalled WB
  valid_needs_wb_ready: assert property (
    @(posedge clk) disable iff (!rst_n) ex_valid_i |-> wb_ready_i
  ) else begin
    fail_count++;
    $error("ex_valid_o high while wb_ready_i is low");
  end

  // MULH stall lasts one cycle, multiplier ready again after it
  mulh_stall_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) mult_multicycle_i |=> mult_ready_i
  ) else begin
    fail_count++;
    $error("Multiplier not ready in the cycle after the MULH stall");
  end

  // No WB write while in reset
  no_wb_write_in_reset: assert property (
    @(posedge clk) !rst_n |-> !regfile_we_wb_i
  ) else begin
    fail_count++;
    $error("regfile_we_wb_o high during reset");
  end

endmodule

bind ex_stage tb_ex_stage_checker i_tb_ex_stage_checker (
  .clk               (clk),
  .rst_n             (rst_n),
  .ex_valid_i        (ex_valid_o),
  .wb_ready_i        (wb_ready_i),
  .mult_multicycle_i (mult_multicycle_o),
  .mult_ready_i      (res.mult_ready),
  .regfile_we_wb_i   (regfile_we_wb_o)
);

// File: tb_ex_stage.sv
//////////////////////////////
// Vector-driven testbench for the execute stage
// Clock, reset, vector reader, output checks, cycle timeout
//////////////////////////////

`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

  localparam int N_WSPR = 4;
  localparam int IDX_W  = $clog2(N_WSPR);
  localparam int N_FLD  = 21;  // Fields per vector line

  logic                  clk;
  logic                  rst_n;
  logic                  alu_en_i, mult_en_i, sprw_en_i, lsu_en_i;
  alu_op_e               alu_operator_i;
  mult_op_e              mult_operator_i;
  logic [DATA_W-1:0]     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  logic [DATA_W-1:0]     mult_operand_a_i, mult_operand_b_i, mult_operand_c_i;
  logic [DATA_W-1:0]     mult_dot_op_a_i, mult_dot_op_b_i;
  logic [IDX_W-1:0]      sprw_idx_i;
  logic [DATA_W-1:0]     lsu_rdata_i, csr_rdata_i;
  logic                  lsu_ready_ex_i, lsu_err_i, csr_access_i, branch_in_ex_i;
  logic                  regfile_alu_we_i, regfile_we_i, wb_ready_i;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i, regfile_waddr_i;
  logic                  mult_multicycle_o, regfile_alu_we_o, load_compute_o;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_o, regfile_waddr_wb_o;
  logic [DATA_W-1:0]     regfile_alu_wdata_o, regfile_wdata_wb_o, jump_target_o;
  logic                  regfile_we_wb_o, branch_decision_o, ex_ready_o, ex_valid_o;

  string       vec_lines[$];  // Raw vector lines, comments dropped
  logic [31:0] fld [N_FLD];   // Fields of the current vector
  int          vec_idx;
  int unsigned cycle_count  = 0;
  int unsigned cycle_limit  = 0;  // Zero until vectors are loaded

  ex_stage #(.N_WSPR(N_WSPR)) i_ex_stage (.*);

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Timeout
  //////////////////////////////
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: run went past %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped by cycle limit");
    end
  end

  task automatic drive_idle();
    {alu_en_i, mult_en_i, sprw_en_i, lsu_en_i} = '0;
    {lsu_ready_ex_i, lsu_err_i, csr_access_i, branch_in_ex_i} = '0;
    {regfile_alu_we_i, regfile_we_i, wb_ready_i} = '0;
    alu_operator_i      = ALU_ADD;
    mult_operator_i     = MUL_LO;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_operand_c_i    = '0;
    mult_dot_op_a_i     = '0;
    mult_dot_op_b_i     = '0;
    sprw_idx_i          = '0;
    lsu_rdata_i         = '0;
    csr_rdata_i         = '0;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
  endtask

  // Keeps data lines only, skips # comments and blank lines
  task automatic load_vectors();
    int    fd;
    string line;
    fd = $fopen("ex_stage_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open ex_stage_vectors.txt");
      $display("ERRORS FOUND");
      $fatal(1, "Missing vector file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != 8'h23 && line.getc(0) != 8'h0a) begin
        vec_lines.push_back(line);
      end
    end
    $fclose(fd);
    if (vec_lines.size() == 0) begin
      $display("Vector file holds no vectors");
      $display("ERRORS FOUND");
      $fatal(1, "Empty vector file");
    end
  endtask

  //////////////////////////////
  // Vector apply
  //////////////////////////////
  task automatic apply_vector(input string line);
    int n;
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                fld[14], fld[15], fld[16], fld[17], fld[18], fld[19], fld[20]);
    if (n != N_FLD) begin
      $display("Vector %0d is malformed, read %0d fields", vec_idx, n);
      $display("ERRORS FOUND");
      $fatal(1, "Bad vector line");
    end
    alu_en_i         = fld[0][0];   // Control bit map of column 1
    mult_en_i        = fld[0][1];
    csr_access_i     = fld[0][2];
    lsu_en_i         = fld[0][3];
    sprw_en_i        = fld[0][4];
    lsu_ready_ex_i   = fld[0][5];
    lsu_err_i        = fld[0][6];
    branch_in_ex_i   = fld[0][7];
    regfile_alu_we_i = fld[0][8];
    regfile_we_i     = fld[0][9];
    wb_ready_i       = fld[0][10];
    alu_operator_i      = alu_op_e'(fld[1][3:0]);
    mult_operator_i     = mult_op_e'(fld[2][1:0]);
    sprw_idx_i          = fld[3][IDX_W-1:0];
    regfile_alu_waddr_i = fld[4][REG_ADDR_W-1:0];
    regfile_waddr_i     = fld[5][REG_ADDR_W-1:0];
    alu_operand_a_i     = fld[6];
    alu_operand_b_i     = fld[7];
    alu_operand_c_i     = fld[8];
    mult_operand_a_i    = fld[9];
    mult_operand_b_i    = fld[10];
    mult_operand_c_i    = fld[11];
    mult_dot_op_a_i     = fld[12];
    mult_dot_op_b_i     = fld[13];
    lsu_rdata_i         = fld[14];
    csr_rdata_i         = fld[15];
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: vector %0d %s got %h expected %h",
               $time, vec_idx, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Output mismatch");
    end
  endtask

  //////////////////////////////
  // Output compare
  //////////////////////////////
  task automatic check_outputs();
    logic [31:0] flags;
    logic [31:0] mask;
    flags = fld[16];  // branch, ready, valid, multicycle, load_compute, we_wb
    mask  = fld[17];
    // Pass-through outputs, always checked against the driven inputs
    check_value("jump_target_o", jump_target_o, alu_operand_c_i);
    check_value("regfile_alu_we_o", {31'b0, regfile_alu_we_o}, {31'b0, regfile_alu_we_i});
    check_value("regfile_alu_waddr_o", {26'b0, regfile_alu_waddr_o},
                {26'b0, regfile_alu_waddr_i});
    if (mask[0]) check_value("branch_decision_o", {31'b0, branch_decision_o}, {31'b0, flags[0]});
    if (mask[1]) check_value("ex_ready_o", {31'b0, ex_ready_o}, {31'b0, flags[1]});
    if (mask[2]) check_value("ex_valid_o", {31'b0, ex_valid_o}, {31'b0, flags[2]});
    if (mask[3]) check_value("mult_multicycle_o", {31'b0, mult_multicycle_o}, {31'b0, flags[3]});
    if (mask[4]) check_value("load_compute_o", {31'b0, load_compute_o}, {31'b0, flags[4]});
    if (mask[5]) check_value("regfile_we_wb_o", {31'b0, regfile_we_wb_o}, {31'b0, flags[5]});
    if (mask[6]) check_value("regfile_alu_wdata_o", regfile_alu_wdata_o, fld[18]);
    if (mask[7]) check_value("regfile_waddr_wb_o", {26'b0, regfile_waddr_wb_o}, fld[19]);
    if (mask[8]) check_value("regfile_wdata_wb_o", regfile_wdata_wb_o, fld[20]);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    drive_idle();
    rst_n = 1'b0;
    load_vectors();
    cycle_limit = vec_lines.size() + 20;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    for (vec_idx = 0; vec_idx < vec_lines.size(); vec_idx++) begin
      @(posedge clk);
      #1 apply_vector(vec_lines[vec_idx]);  // Inputs settle 1 ns after the edge
      #2.5 check_outputs();                 // Just before the next edge
    end
    @(posedge clk);  // Bound assertions sample the last vector here
    #1;
    if (i_ex_stage.i_tb_ex_stage_checker.fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times",
               i_ex_stage.i_tb_ex_stage_checker.fail_count);
      $display("ERRORS FOUND");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

// File: ex_stage_vectors.txt
# ctrl aop mop sidx alu_waddr waddr alu_a alu_b alu_c mul_a mul_b mul_c dot_a dot_b lsu_rdata csr_rdata
# then expected flags, check mask, fwd wdata, wb waddr, wb wdata (bit maps in tb_ex_stage.sv)
420 0 0 0 00 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 02 1ff 00000000 00 00000000
521 0 0 0 05 00 00000005 00000003 00001000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff 00000008 00 00000000
521 1 0 0 05 00 00000003 00000005 00001004 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff FFFFFFFE 00 00000000
521 2 0 0 05 00 F0F0F0F0 FF00FF00 00001008 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff F000F000 00 00000000
521 3 0 0 05 00 F0F0F0F0 0F000000 0000100C 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff FFF0F0F0 00 00000000
521 4 0 0 05 00 AAAAAAAA FFFF0000 00001010 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff 5555AAAA 00 00000000
521 5 0 0 05 00 00000001 00000024 00001014 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff 00000010 00 00000000
521 6 0 0 05 00 80000000 0000001F 00001018 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff 00000001 00 00000000
521 7 0 0 05 00 80000000 00000004 0000101C 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff F8000000 00 00000000
521 8 0 0 05 00 FFFFFFFF 00000001 00001020 00000000 00000000 00000000 00000000 00000000 00000000 00000000 07 1ff 00000001 00 00000000
521 9 0 0 05 00 FFFFFFFF 00000001 00001024 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff 00000000 00 00000000
5A1 A 0 0 05 00 12345678 12345678 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 07 1ff 00000001 00 00000000
581 B 0 0 05 00 12345678 12345679 00002004 00000000 00000000 00000000 00000000 00000000 00000000 00000000 03 1ff 00000001 00 00000000
522 0 0 0 05 00 00000000 00000000 00000000 0000FFFF 00010001 00000000 00000000 00000000 00000000 00000000 06 1ff FFFFFFFF 00 00000000
522 0 1 0 05 00 00000000 00000000 00000000 12345678 00100000 00000000 00000000 00000000 00000000 00000000 08 1bf 00000000 00 00000000
522 0 1 0 05 00 00000000 00000000 00000000 12345678 00100000 00000000 00000000 00000000 00000000 00000000 06 1ff 00012345 00 00000000
522 0 2 0 05 00 00000000 00000000 00000000 00000000 00000000 00000064 0003FFFE 00050007 00000000 00000000 06 1ff 00000065 00 00000000
522 0 3 0 05 00 00000000 00000000 00000000 00000000 00000000 FFFFFFF0 7F80FF02 01020304 00000000 00000000 06 1ff FFFFFF74 00 00000000
526 0 3 0 05 00 00000000 00000000 00000000 00000000 00000000 FFFFFFF0 7F80FF02 01020304 00000000 CAFEF00D 06 1ff CAFEF00D 00 00000000
638 0 0 2 00 0A 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff 00000000 00 00000000
420 0 0 0 00 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0A0B0C0D 00000000 22 1ff 00000000 0A 00000000
532 0 2 2 05 00 00000000 00000000 00000000 00000000 00000000 00000000 11111111 00020003 00000000 00000000 06 1ff 0000383D 0A 00000000
523 0 2 0 05 00 00000100 00000023 00003000 00000000 00000000 00000000 00010001 00050006 00000000 00000000 16 1ff 00000123 0A 0000383D
678 0 0 3 00 0E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff 00000000 0A 00000000
420 0 0 0 00 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 DEADBEEF 00000000 02 1ff 00000000 0A 00000000
532 0 2 3 05 00 00000000 00000000 00000000 00000000 00000000 00000007 11111111 00010001 00000000 00000000 06 1ff 00000007 0A 00000000
628 0 0 0 00 15 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 06 1ff 00000000 0A 00000007
121 0 0 0 05 00 00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000 55AA55AA 00000000 20 1ff 00000002 15 55AA55AA
121 0 0 0 05 00 00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000 12121212 00000000 20 1ff 00000002 15 12121212
420 0 0 0 00 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 22 1ff 00000000 15 00000000
420 0 0 0 00 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 02 1ff 00000000 15 00000000

// File: sim.f
ex_pkg.sv
ex_result_if.sv
ex_alu.sv
ex_mult.sv
ex_spr_file.sv
ex_wb_stage.sv
ex_fwd_ctrl.sv
ex_stage.sv
tb_ex_stage_checker.sv
tb_ex_stage.sv

// File: run_sim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage \
  -f sim.f -o tb_ex_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_ex_stage > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
